// ==== common/fe_cfg.svh ====
// Front end build parameters, shared by RTL and testbench
// Cache and store sizes must be powers of two; the PC is byte addressed, the words are 32 bit
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// Data and address width
`define FE_WORD_W       32

// PC after reset
`define FE_RESET_VECTOR 32'h0000_0000

// One word per cache line, direct mapped
`define FE_CACHE_LINES  8

// Miss detection to line write, in cycles
`define FE_FILL_CYCLES  3

// Instruction store depth in words
`define FE_ROM_WORDS    64

// Opcode class 0, all other fields zero
`define FE_NOP          32'h0000_0000

`endif

// ==== common/fe_pkg.sv ====
// Types for the fetch and decode path
// The opcode sits in bits 31:26 in both instruction formats
`default_nettype none

`include "fe_cfg.svh"

package fe_pkg;

    typedef logic [`FE_WORD_W-1:0] word_t;  // PCs and instruction words

    typedef enum logic [5:0] {
        OP_NOP    = 6'h00,
        OP_ALU_R  = 6'h01,  // rc = ra op rb
        OP_ALU_I  = 6'h02,  // rc = ra op imm
        OP_LOAD   = 6'h03,  // rc = mem[ra + imm]
        OP_STORE  = 6'h04,  // mem[ra + func] = rb
        OP_BRANCH = 6'h05   // Compare ra, rc; offset in imm
    } opcode_e;

    // Register format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [10:0] func;  // ALU function, or store offset
    } r_fmt_t;

    // Immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  ra;
        logic [4:0]  rc;
        logic [15:0] imm;
    } i_fmt_t;

    // One fetched word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } insn_u;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
    } if_id_t;

    // Driven by the later stages
    typedef struct packed {
        logic  flush;
        word_t new_pc;
        logic  br_taken;
        word_t br_addr;
    } redirect_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        opcode_e    opcode;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        word_t      imm;      // Sign-extended
        logic       use_imm;
        logic       illegal;
    } id_ctrl_t;

endpackage

`default_nettype wire

// ==== decode/insn_decode.sv ====
// ID stage register with field decode
// ALU register and store use the register format, other opcodes the immediate format
`timescale 1ns/1ns
`default_nettype none

`include "fe_cfg.svh"

module insn_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             stall,
    input  fe_pkg::if_id_t   if_id,
    output fe_pkg::id_ctrl_t id_out
);

    import fe_pkg::*;

    insn_u    fmt;   // Fetched word, both views
    id_ctrl_t ctrl;  // Next ID contents

    assign fmt = if_id.insn;

    always_comb begin
        ctrl         = '0;
        ctrl.valid   = if_id.valid;
        ctrl.pc      = if_id.pc;
        ctrl.opcode  = opcode_e'(fmt.r.opcode);  // Same bits in both formats
        ctrl.rs1     = fmt.r.ra;
        case (fmt.r.opcode)
            OP_ALU_R, OP_STORE: begin
                ctrl.rs2     = fmt.r.rb;
                ctrl.rd      = fmt.r.rc;
                ctrl.imm     = {{(`FE_WORD_W-11){fmt.r.func[10]}}, fmt.r.func};
                ctrl.use_imm = (fmt.r.opcode == OP_STORE);  // Store offset in func
            end
            OP_NOP, OP_ALU_I, OP_LOAD, OP_BRANCH: begin
                ctrl.rs2     = '0;
                ctrl.rd      = fmt.i.rc;
                ctrl.imm     = {{(`FE_WORD_W-16){fmt.i.imm[15]}}, fmt.i.imm};
                ctrl.use_imm = 1'b1;
            end
            default: begin
                ctrl.rs2     = '0;
                ctrl.rd      = fmt.i.rc;  // Immediate view
                ctrl.imm     = {{(`FE_WORD_W-16){fmt.i.imm[15]}}, fmt.i.imm};
                ctrl.use_imm = 1'b1;
                ctrl.illegal = 1'b1;      // Unknown opcode class
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_out         <= '0;
            id_out.opcode  <= OP_NOP;
        end else if (!stall) begin
            id_out <= ctrl;  // Valid follows IF/ID
        end
    end

    // Later stages trust opcode when illegal is clear
    a_illegal_flag: assert property (
        @(posedge clk) disable iff (!arst_n)
        id_out.valid && !(id_out.opcode inside {OP_NOP, OP_ALU_R, OP_ALU_I,
                                                OP_LOAD, OP_STORE, OP_BRANCH})
            |-> id_out.illegal
    ) else $error("unknown opcode %h without illegal", id_out.opcode);

endmodule

`default_nettype wire

// ==== fetch/fetch_reg.sv ====
// Program counter and IF/ID register
// Redirects are taken only on an edge with rdy high and stall low
`timescale 1ns/1ns
`default_nettype none

`include "fe_cfg.svh"

module fetch_reg (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             rdy,       // Cache hit on fetch_pc
    input  logic             stall,     // Hold from later stages
    input  fe_pkg::redirect_t redirect,
    input  fe_pkg::word_t    insn,      // Word at fetch_pc, valid with rdy
    output fe_pkg::word_t    fetch_pc,
    output fe_pkg::if_id_t   if_id
);

    import fe_pkg::*;

    logic advance;  // Pipeline may move this cycle

    assign advance = rdy && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc    <= `FE_RESET_VECTOR;
            if_id.valid <= 1'b0;
            if_id.pc    <= '0;
            if_id.insn  <= `FE_NOP;
        end else if (advance) begin
            if (redirect.flush) begin
                fetch_pc    <= redirect.new_pc;  // Flush wins over branch
                if_id.valid <= 1'b0;
                if_id.insn  <= `FE_NOP;
            end else if (redirect.br_taken) begin
                fetch_pc    <= redirect.br_addr;
                if_id.valid <= 1'b0;             // Word in flight dropped
                if_id.insn  <= `FE_NOP;
            end else begin
                if_id.valid <= 1'b1;
                if_id.pc    <= fetch_pc;
                if_id.insn  <= insn;
                fetch_pc    <= fetch_pc + word_t'(4);  // Next sequential word
            end
        end
    end

    // Misaligned targets would break the cache index
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        fetch_pc[1:0] == 2'b00
    ) else $error("fetch_pc not word aligned: %h", fetch_pc);

    // Decode relies on IF/ID holding through a stall
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> $stable(if_id)
    ) else $error("if_id changed under stall");

endmodule

`default_nettype wire

// ==== fetch/insn_cache.sv ====
// Direct-mapped, one word per line, read only
// Hit is combinational; a miss takes FE_FILL_CYCLES + 1 cycles, one fill at a time
`timescale 1ns/1ns
`default_nettype none

`include "fe_cfg.svh"

module insn_cache (
    input  logic          clk,
    input  logic          arst_n,
    input  fe_pkg::word_t addr,      // Fetch address
    output logic          rdy,       // Tag hit
    output fe_pkg::word_t insn,
    output logic          rom_req,   // One-cycle fill request
    output fe_pkg::word_t rom_addr,
    input  fe_pkg::word_t rom_data   // Valid one cycle after rom_req
);

    import fe_pkg::*;

    localparam int IDX_W = $clog2(`FE_CACHE_LINES);
    localparam int TAG_W = `FE_WORD_W - IDX_W - 2;    // Byte offset bits dropped
    localparam int CNT_W = $clog2(`FE_FILL_CYCLES + 1);

    logic [TAG_W-1:0]      tag_q  [`FE_CACHE_LINES];
    word_t                 data_q [`FE_CACHE_LINES];
    logic [`FE_CACHE_LINES-1:0] valid_q;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;

    logic             busy_q;      // Fill in flight
    logic [CNT_W-1:0] cnt_q;       // Cycles since request
    word_t            fill_addr_q; // Line being filled
    logic             fill_done;
    logic [IDX_W-1:0] fill_idx;

    assign idx = addr[2 +: IDX_W];
    assign tag = addr[`FE_WORD_W-1 -: TAG_W];
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    assign rdy  = hit;
    assign insn = hit ? data_q[idx] : `FE_NOP;  // No X into IF/ID on a miss

    assign rom_req  = !hit && !busy_q;
    assign rom_addr = addr;

    assign fill_done = busy_q && (cnt_q == CNT_W'(`FE_FILL_CYCLES));
    assign fill_idx  = fill_addr_q[2 +: IDX_W];

    // Fill sequencing and line valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            valid_q <= '0;
        end else if (rom_req) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(1);
        end else if (fill_done) begin
            busy_q            <= 1'b0;
            cnt_q             <= '0;
            valid_q[fill_idx] <= 1'b1;  // Next lookup hits
        end else if (busy_q) begin
            cnt_q <= cnt_q + CNT_W'(1);
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (rom_req) begin
            fill_addr_q <= addr;
        end
        if (fill_done) begin
            tag_q[fill_idx]  <= fill_addr_q[`FE_WORD_W-1 -: TAG_W];
            data_q[fill_idx] <= rom_data;  // Store holds its output until next req
        end
    end

    // A request is followed by a full fill window without another one
    a_one_fill: assert property (
        @(posedge clk) disable iff (!arst_n)
        rom_req |=> !rom_req [*`FE_FILL_CYCLES]
    ) else $error("rom_req during fill");

endmodule

`default_nettype wire

// ==== rtl/front_end.sv ====
// Fetch and decode front end of the core
// stall and redirect come as levels from the later stages, no handshake
`timescale 1ns/1ns
`default_nettype none

`include "fe_cfg.svh"

module front_end (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              stall,
    input  fe_pkg::redirect_t redirect,
    output fe_pkg::id_ctrl_t  id_out,
    output fe_pkg::word_t     fetch_pc,
    output logic              rdy
);

    import fe_pkg::*;

    word_t  cache_insn;  // Word at fetch_pc on a hit
    logic   rom_req;
    word_t  rom_addr;
    word_t  rom_data;
    if_id_t if_id;

    fetch_reg u_fetch_reg (
        .clk      (clk),
        .arst_n   (arst_n),
        .rdy      (rdy),
        .stall    (stall),
        .redirect (redirect),
        .insn     (cache_insn),
        .fetch_pc (fetch_pc),
        .if_id    (if_id)
    );

    insn_cache u_insn_cache (
        .clk      (clk),
        .arst_n   (arst_n),
        .addr     (fetch_pc),
        .rdy      (rdy),
        .insn     (cache_insn),
        .rom_req  (rom_req),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    insn_rom u_insn_rom (
        .clk  (clk),
        .req  (rom_req),
        .addr (rom_addr),
        .data (rom_data)
    );

    insn_decode u_insn_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall),
        .if_id  (if_id),
        .id_out (id_out)
    );

endmodule

`default_nettype wire

// ==== rtl/insn_rom.sv ====
// Read-only instruction store, loaded from sim/program.hex at elaboration
// Output updates only on req and holds otherwise; words past the image read as NOP
`timescale 1ns/1ns
`default_nettype none

`include "fe_cfg.svh"

module insn_rom (
    input  logic          clk,
    input  logic          req,   // Read strobe
    input  fe_pkg::word_t addr,  // Byte address
    output fe_pkg::word_t data   // Valid the cycle after req
);

    import fe_pkg::*;

    localparam int AW = $clog2(`FE_ROM_WORDS);

    word_t mem [`FE_ROM_WORDS];

    logic [`FE_WORD_W-3:0] word_idx;
    logic                  in_range;

    initial begin
        for (int i = 0; i < `FE_ROM_WORDS; i++) begin
            mem[i] = `FE_NOP;  // Image may be shorter than the store
        end
        $readmemh("sim/program.hex", mem);
    end

    assign word_idx = addr[`FE_WORD_W-1:2];
    assign in_range = word_idx < (`FE_WORD_W-2)'(`FE_ROM_WORDS);

    always_ff @(posedge clk) begin
        if (req) begin
            data <= in_range ? mem[word_idx[AW-1:0]] : `FE_NOP;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the front end testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_front_end \
    -f verilog.f \
    -o sim_front_end

./obj_dir/sim_front_end | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== sim/program.hex ====
// One 32-bit instruction word per line in hex, starting at word address 0
// Opcode in bits 31:26; words past the last line read as NOP
04221805
0885FFF0
0CC70010
110907FC
154B8000
00000000
FC21ABCD
04A63C2A
08E87FFF
0D2A8001
116B6123
1400FFFC
18431234
07FFFFFF
0BFFFFFF
00000001
0C010004
13E007FF
80000000
04000000
08420001
1421FFF8

// ==== sim/tb_front_end.sv ====
// Testbench for the fetch and decode front end
// Reference model takes rdy as its only timing input and reads sim/program.hex itself
// Branch and flush targets in the table must be word aligned
`timescale 1ns/1ns
`default_nettype none

`include "fe_cfg.svh"

module tb_front_end;

    import fe_pkg::*;

    localparam int WAIT_LIMIT  = 400;  // Cycles per wait before giving up
    localparam int RAND_CYCLES = 120;
    localparam int IDX_W       = $clog2(`FE_CACHE_LINES);
    localparam int ROM_AW      = $clog2(`FE_ROM_WORDS);

    typedef struct packed {
        logic       stall;
        logic       flush;
        word_t      new_pc;
        logic       br_taken;
        word_t      br_addr;
        logic [7:0] hold;  // Words to deliver, or cycles when stall is set
    } step_t;

    logic      clk;
    logic      arst_n;
    logic      stall;
    redirect_t redirect;
    id_ctrl_t  id_out;
    word_t     fetch_pc;
    logic      rdy;

    word_t     img [`FE_ROM_WORDS];  // Own copy of the program image
    step_t     steps [$];
    integer    seed;
    int        mismatch_errs;
    int        timeout_errs;
    int        checks;
    int        delivered;            // Fresh words that reached id_out
    int        redirects;            // Redirects taken by the fetch register
    logic      timed_out;

    // Reference model
    word_t     m_pc;
    logic      m_ifid_v;
    logic      m_ifid_fresh;         // IF/ID word not yet seen by decode
    word_t     m_ifid_pc;
    word_t     m_ifid_insn;
    id_ctrl_t  m_id;
    logic      m_line_v [`FE_CACHE_LINES];
    word_t     m_line_a [`FE_CACHE_LINES];

    front_end u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .stall    (stall),
        .redirect (redirect),
        .id_out   (id_out),
        .fetch_pc (fetch_pc),
        .rdy      (rdy)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic word_t image_word(input word_t a);
        if ((a >> 2) < `FE_ROM_WORDS) begin
            return img[a[2 +: ROM_AW]];
        end
        return `FE_NOP;  // Past the store
    endfunction

    // Expected ID contents from the format rules
    function automatic id_ctrl_t expect_ctrl(input logic v, input word_t pc, input word_t w);
        id_ctrl_t   c;
        logic [5:0] op;
        op       = w[31:26];
        c        = '0;
        c.valid  = v;
        c.pc     = pc;
        c.opcode = opcode_e'(op);
        c.rs1    = w[25:21];
        if (op == OP_ALU_R || op == OP_STORE) begin
            c.rs2     = w[20:16];                          // Register format
            c.rd      = w[15:11];
            c.imm     = {{(`FE_WORD_W-11){w[10]}}, w[10:0]};
            c.use_imm = (op == OP_STORE);
        end else begin
            c.rd      = w[20:16];                          // Immediate format
            c.imm     = {{(`FE_WORD_W-16){w[15]}}, w[15:0]};
            c.use_imm = 1'b1;
            c.illegal = (op > OP_BRANCH);
        end
        return c;
    endfunction

    task automatic check_ctrl(input string name, input id_ctrl_t got, input id_ctrl_t exp);
        checks++;
        if (got !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s got=%h exp=%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s got=%h exp=%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s got=%h exp=%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic reset_model();
        m_pc         = `FE_RESET_VECTOR;
        m_ifid_v     = 1'b0;
        m_ifid_fresh = 1'b0;
        m_ifid_pc    = '0;
        m_ifid_insn  = `FE_NOP;
        m_id         = '0;
        for (int i = 0; i < `FE_CACHE_LINES; i++) begin
            m_line_v[i] = 1'b0;
        end
    endtask

    // Predicts the coming rising edge; decode sees the old IF/ID
    task automatic step_model();
        if (!stall) begin
            m_id = expect_ctrl(m_ifid_v, m_ifid_pc, m_ifid_insn);
            if (m_ifid_fresh) begin
                delivered++;
                m_ifid_fresh = 1'b0;
            end
        end
        if (rdy && !stall) begin
            if (redirect.flush || redirect.br_taken) begin
                m_pc         = redirect.flush ? redirect.new_pc : redirect.br_addr;
                m_ifid_v     = 1'b0;  // Word in flight dropped
                m_ifid_fresh = 1'b0;
                m_ifid_insn  = `FE_NOP;
                redirects++;
            end else begin
                m_ifid_v     = 1'b1;
                m_ifid_fresh = 1'b1;
                m_ifid_pc    = m_pc;
                m_ifid_insn  = image_word(m_pc);
                m_pc         = m_pc + 32'd4;
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            check_word("fetch_pc", fetch_pc, m_pc);
            check_ctrl("id_out", id_out, m_id);
            if (m_line_v[m_pc[2 +: IDX_W]] && m_line_a[m_pc[2 +: IDX_W]] == m_pc) begin
                check_bit("rdy", rdy, 1'b1);  // Line filled earlier, must hit
            end
            if (rdy) begin
                m_line_v[m_pc[2 +: IDX_W]] = 1'b1;
                m_line_a[m_pc[2 +: IDX_W]] = m_pc;
            end
            step_model();
        end
    end

    task automatic wait_words(input int n);
        int target;
        int t;
        target = delivered + n;
        t      = 0;
        while (delivered < target && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (delivered < target) begin
            timeout_errs++;
            timed_out = 1'b1;
            $display("Timeout: %0d words still missing at id_out", target - delivered);
        end
    endtask

    task automatic wait_redirect(input int start);
        int t;
        t = 0;
        while (redirects == start && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (redirects == start) begin
            timeout_errs++;
            timed_out = 1'b1;
            $display("Timeout: redirect not taken within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic add_step(input logic st, input logic fl, input word_t npc,
                            input logic br, input word_t baddr, input int hold);
        step_t s;
        s.stall    = st;
        s.flush    = fl;
        s.new_pc   = npc;
        s.br_taken = br;
        s.br_addr  = baddr;
        s.hold     = 8'(hold);
        steps.push_back(s);
    endtask

    task automatic apply_step(input step_t s);
        int start;
        @(posedge clk);
        #2;
        stall             = s.stall;
        redirect.flush    = s.flush;
        redirect.new_pc   = s.new_pc;
        redirect.br_taken = s.br_taken;
        redirect.br_addr  = s.br_addr;
        start             = redirects;
        if (s.flush || s.br_taken) begin
            wait_redirect(start);
            #2;
            redirect = '0;  // Level held until taken
        end
        if (s.stall) begin
            for (int c = 0; c < s.hold; c++) begin
                @(posedge clk);
            end
        end else if (!timed_out) begin
            wait_words(s.hold);
        end
    endtask

    task automatic random_stalls();
        integer r;
        for (int c = 0; c < RAND_CYCLES; c++) begin
            @(posedge clk);
            #2;
            r     = $random(seed);
            stall = r[0];
        end
        @(posedge clk);
        #2;
        stall = 1'b0;
    endtask

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        stall         = 1'b0;
        redirect      = '0;
        seed          = 81200;
        mismatch_errs = 0;
        timeout_errs  = 0;
        checks        = 0;
        delivered     = 0;
        redirects     = 0;
        timed_out     = 1'b0;
        for (int i = 0; i < `FE_ROM_WORDS; i++) begin
            img[i] = `FE_NOP;  // Image shorter than the store
        end
        $readmemh("sim/program.hex", img);

        add_step(1'b0, 1'b0, 32'h0,   1'b0, 32'h0,  24);  // Cold run, every line misses
        add_step(1'b0, 1'b0, 32'h0,   1'b1, 32'h08, 4);
        add_step(1'b0, 1'b0, 32'h0,   1'b1, 32'h08, 4);   // Same lines again, hits
        add_step(1'b1, 1'b0, 32'h0,   1'b0, 32'h0,  6);
        add_step(1'b0, 1'b1, 32'h30,  1'b1, 32'h0C, 5);   // Flush beats branch
        add_step(1'b0, 1'b0, 32'h0,   1'b1, 32'h40, 4);
        add_step(1'b0, 1'b1, 32'h100, 1'b0, 32'h0,  3);   // Past the store, NOPs
        add_step(1'b0, 1'b1, 32'h00,  1'b0, 32'h0,  6);
        add_step(1'b1, 1'b0, 32'h0,   1'b0, 32'h0,  3);
        add_step(1'b0, 1'b0, 32'h0,   1'b1, 32'h14, 6);
        add_step(1'b0, 1'b0, 32'h0,   1'b0, 32'h0,  8);

        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_word("fetch_pc", fetch_pc, `FE_RESET_VECTOR);
        check_bit("rdy", rdy, 1'b0);
        check_bit("id_out.valid", id_out.valid, 1'b0);

        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            apply_step(steps[i]);
        end
        if (!timed_out) begin
            random_stalls();
            wait_words(4);
        end

        $display("Errors: %0d mismatches, %0d timeouts, %0d checks, %0d words delivered",
                 mismatch_errs, timeout_errs, checks, delivered);
        if (mismatch_errs == 0 && timeout_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/fe_pkg.sv
fetch/fetch_reg.sv
fetch/insn_cache.sv
rtl/insn_rom.sv
decode/insn_decode.sv
rtl/front_end.sv
sim/tb_front_end.sv
